//--- Makefile
# Verilator build and run for the media loader testbench

VERILATOR ?= verilator
TOP       ?= media_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/media_pkg.sv
`default_nettype none

package media_pkg;

	//////////////////////////////
	// Widths with a meaning
	//////////////////////////////
	typedef logic [7:0]  byte_t;
	typedef logic [24:0] dl_addr_t;
	// Bank[24:23], page[22:14], in-page address[13:0]
	typedef logic [24:0] mem_addr_t;
	typedef logic [8:0]  page_t;
	typedef logic [22:0] tape_addr_t;
	typedef logic [1:0]  bank_t;

	// Bank codes
	localparam bank_t BANK_MODEL_A = 2'd0;
	localparam bank_t BANK_MODEL_B = 2'd1;
	localparam bank_t BANK_TAPE    = 2'd2;

	// Fixed system ROM pages
	localparam page_t PAGE_OS      = 9'h000;
	localparam page_t PAGE_BASIC   = 9'h100;
	localparam page_t PAGE_DISK    = 9'h107;
	localparam page_t PAGE_MONITOR = 9'h0FF;
	// Unused page for a bad extension
	localparam page_t PAGE_SPARE   = 9'h1EE;

	localparam byte_t TAPE_INDEX = 8'd4;

	//////////////////////////////
	// Memory slot timing
	//////////////////////////////
	localparam int SLOT_DIV = 8;
	localparam int SLOT_W   = $clog2(SLOT_DIV);
	typedef logic [SLOT_W-1:0] slot_cnt_t;
	localparam slot_cnt_t SLOT_LAST = slot_cnt_t'(SLOT_DIV - 1);
	// Winner is picked in the cycle before the slot
	localparam slot_cnt_t SLOT_PRE  = slot_cnt_t'(SLOT_DIV - 2);

	typedef struct packed {
		logic     wr;
		dl_addr_t addr;
		byte_t    data;
	} dl_t;

	typedef struct packed {
		mem_addr_t addr;
		byte_t     data;
		logic      we;
	} mem_req_t;

	typedef enum logic [1:0] {
		idle,
		grant_rom,
		grant_tape_wr,
		grant_tape_rd
	} arb_state_t;

endpackage

`default_nettype wire

//--- hw/media_top.sv
`timescale 1ns/10ps
`default_nettype none

module media_top import media_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  dl_t          dl,
	input  logic         download,
	input  byte_t        dl_index,
	input  logic [15:0]  dl_ext,
	output logic         dl_wait,
	input  logic         tape_req,
	input  logic         tape_rewind,
	output logic         tape_ack,
	output byte_t        tape_data,
	output logic         mem_strobe,
	output mem_req_t     mem_req,
	input  byte_t        mem_rdata,
	output logic [255:0] rom_map
);

	mem_req_t  rom_req;
	logic      rom_grant;
	mem_req_t  tape_wr_req;
	logic      tape_wr_pending;
	logic      tape_wr_grant;
	logic      tape_rd_pending;
	mem_addr_t tape_rd_addr;
	logic      tape_rd_done;

	// The host waits exactly while a ROM write is pending
	rom_loader rom_loader_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.download    (download),
		.dl_index    (dl_index),
		.dl_ext      (dl_ext),
		.rom_pending (dl_wait),
		.rom_req     (rom_req),
		.rom_grant   (rom_grant),
		.rom_map     (rom_map)
	);

	tape_buffer tape_buffer_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.dl              (dl),
		.download        (download),
		.dl_index        (dl_index),
		.tape_rewind     (tape_rewind),
		.tape_req        (tape_req),
		.tape_wr_pending (tape_wr_pending),
		.tape_wr_req     (tape_wr_req),
		.tape_wr_grant   (tape_wr_grant),
		.tape_rd_pending (tape_rd_pending),
		.tape_rd_addr    (tape_rd_addr),
		.tape_rd_done    (tape_rd_done),
		.mem_rdata       (mem_rdata),
		.tape_ack        (tape_ack),
		.tape_data       (tape_data)
	);

	mem_arbiter mem_arbiter_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.rom_pending     (dl_wait),
		.rom_req         (rom_req),
		.tape_wr_pending (tape_wr_pending),
		.tape_wr_req     (tape_wr_req),
		.tape_rd_pending (tape_rd_pending),
		.tape_rd_addr    (tape_rd_addr),
		.rom_grant       (rom_grant),
		.tape_wr_grant   (tape_wr_grant),
		.tape_rd_done    (tape_rd_done),
		.mem_strobe      (mem_strobe),
		.mem_req         (mem_req)
	);

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter import media_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      rom_pending,
	input  mem_req_t  rom_req,
	input  logic      tape_wr_pending,
	input  mem_req_t  tape_wr_req,
	input  logic      tape_rd_pending,
	input  mem_addr_t tape_rd_addr,
	output logic      rom_grant,
	output logic      tape_wr_grant,
	output logic      tape_rd_done,
	output logic      mem_strobe,
	output mem_req_t  mem_req
);

	slot_cnt_t  slot_cnt;
	arb_state_t state;
	arb_state_t state_next;
	logic       pre_slot;

	assign pre_slot = (slot_cnt == SLOT_PRE);

	// Winner is picked one cycle early so the strobe lands on the slot
	always_comb begin
		state_next = idle;
		if (pre_slot) begin
			if (rom_pending && rom_req.we)
				state_next = grant_rom;
			else if (tape_wr_pending)
				state_next = grant_tape_wr;
			else if (tape_rd_pending)
				state_next = grant_tape_rd;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			slot_cnt     <= '0;
			state        <= idle;
			tape_rd_done <= 1'b0;
		end else begin
			if (slot_cnt == SLOT_LAST)
				slot_cnt <= '0;
			else
				slot_cnt <= slot_cnt + slot_cnt_t'(1);
			state <= state_next;
			// fixed read latency of one cycle
			tape_rd_done <= (state == grant_tape_rd);
		end
	end

	//////////////////////////////
	// Memory port
	//////////////////////////////
	assign mem_strobe    = (state != idle);
	assign rom_grant     = (state == grant_rom);
	assign tape_wr_grant = (state == grant_tape_wr);

	always_comb begin
		case (state)
			grant_rom:     mem_req = rom_req;
			grant_tape_wr: mem_req = tape_wr_req;
			grant_tape_rd: begin
				mem_req.addr = tape_rd_addr;
				mem_req.data = '0;
				mem_req.we   = 1'b0;
			end
			default:       mem_req = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/rom_loader.sv
`timescale 1ns/10ps
`default_nettype none

module rom_loader import media_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  dl_t          dl,
	input  logic         download,
	input  byte_t        dl_index,
	input  logic [15:0]  dl_ext,
	output logic         rom_pending,
	output mem_req_t     rom_req,
	input  logic         rom_grant,
	output logic [255:0] rom_map
);

	// Returns {valid, value} for one hex character
	function automatic logic [4:0] hex_digit(input byte_t c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	logic        download_q;
	logic        rom_file;
	logic        exp_file;
	logic        rom_strobe;
	logic [4:0]  hi_dig;
	logic [4:0]  lo_dig;
	logic [10:0] seg;
	logic        seg_ok;
	page_t       exp_page;
	page_t       fix_page;
	bank_t       fix_bank;
	mem_addr_t   wr_addr;

	assign rom_file   = download && (dl_index != TAPE_INDEX);
	assign exp_file   = (dl_index != 8'd0) && (dl_index != TAPE_INDEX);
	assign rom_strobe = rom_file && dl.wr;
	assign hi_dig     = hex_digit(dl_ext[15:8]);
	assign lo_dig     = hex_digit(dl_ext[7:0]);

	// Only system ROM segments 0..7 are mapped
	assign seg      = dl.addr[24:14];
	assign seg_ok   = (seg < 11'd8);
	assign fix_bank = seg[2] ? BANK_MODEL_B : BANK_MODEL_A;

	always_comb begin
		case (seg[1:0])
			2'd0:    fix_page = PAGE_OS;
			2'd1:    fix_page = PAGE_BASIC;
			2'd2:    fix_page = PAGE_DISK;
			default: fix_page = PAGE_MONITOR;
		endcase
	end

	always_comb begin
		if (exp_file)
			wr_addr = {BANK_MODEL_A, exp_page + dl.addr[22:14], dl.addr[13:0]};
		else
			wr_addr = {fix_bank, fix_page, dl.addr[13:0]};
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			download_q <= 1'b0;
		else
			download_q <= download;
	end

	// Expansion page taken from the file extension at download start
	always_ff @(posedge clk_sys) begin
		if (download && !download_q && exp_file) begin
			if (dl_ext == "ZZ")
				exp_page <= '0;
			else if (hi_dig[4] && lo_dig[4])
				exp_page <= {1'b0, hi_dig[3:0], lo_dig[3:0]};
			else
				exp_page <= PAGE_SPARE;
		end
	end

	// we low marks a strobe that only holds the host for one cycle
	always_ff @(posedge clk_sys) begin
		if (rom_strobe) begin
			rom_req.addr <= wr_addr;
			rom_req.data <= dl.data;
			rom_req.we   <= exp_file || seg_ok;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_pending <= 1'b0;
			rom_map     <= '0;
		end else begin
			if (rom_grant && rom_req.addr[22])
				rom_map[rom_req.addr[21:14]] <= 1'b1;
			if (rom_pending && (rom_grant || !rom_req.we))
				rom_pending <= 1'b0;
			if (rom_strobe)
				rom_pending <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/tape_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module tape_buffer import media_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  dl_t       dl,
	input  logic      download,
	input  byte_t     dl_index,
	input  logic      tape_rewind,
	input  logic      tape_req,
	output logic      tape_wr_pending,
	output mem_req_t  tape_wr_req,
	input  logic      tape_wr_grant,
	output logic      tape_rd_pending,
	output mem_addr_t tape_rd_addr,
	input  logic      tape_rd_done,
	input  byte_t     mem_rdata,
	output logic      tape_ack,
	output byte_t     tape_data
);

	tape_addr_t last_addr;
	tape_addr_t play_addr;
	logic       tape_dl;
	logic       tape_strobe;

	assign tape_dl     = download && (dl_index == TAPE_INDEX);
	assign tape_strobe = tape_dl && dl.wr;

	// A fetch is open while the toggles differ
	assign tape_rd_pending = tape_req ^ tape_ack;
	assign tape_rd_addr    = {BANK_TAPE, play_addr};

	always_ff @(posedge clk_sys) begin
		if (tape_strobe) begin
			tape_wr_req.addr <= {BANK_TAPE, dl.addr[22:0]};
			tape_wr_req.data <= dl.data;
			tape_wr_req.we   <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (tape_rd_done)
			tape_data <= mem_rdata;
	end

	//////////////////////////////
	// Write tracking and playback
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tape_wr_pending <= 1'b0;
			last_addr       <= '0;
			play_addr       <= '0;
			tape_ack        <= 1'b0;
		end else begin
			if (tape_wr_grant)
				tape_wr_pending <= 1'b0;
			if (tape_strobe) begin
				tape_wr_pending <= 1'b1;
				last_addr       <= dl.addr[22:0];
			end

			if (tape_rd_done) begin
				tape_ack <= ~tape_ack;
				// stops on the last byte
				if (play_addr < last_addr)
					play_addr <= play_addr + tape_addr_t'(1);
			end

			// New file or rewind restarts from the top
			if (tape_dl || tape_rewind)
				play_addr <= '0;
		end
	end

endmodule

`default_nettype wire

//--- list.f
hw/media_pkg.sv
hw/rom_loader.sv
hw/tape_buffer.sv
hw/mem_arbiter.sv
hw/media_top.sv
testbench/tb_clock.sv
testbench/media_checker.sv
testbench/media_tb.sv

//--- testbench/media_checker.sv
`timescale 1ns/10ps
`default_nettype none

module media_checker (
	input logic clk_sys,
	input logic reset,
	input logic mem_strobe,
	input logic dl_wait
);

	int unsigned fail_count = 0;

	// One access per slot means never two strobes in a row
	strobe_single: assert property (@(posedge clk_sys) disable iff (reset)
		mem_strobe |=> !mem_strobe)
		else begin
			$error("mem_strobe high on two consecutive cycles");
			fail_count++;
		end

	strobe_in_reset: assert property (@(posedge clk_sys) reset |=> !mem_strobe)
		else begin
			$error("mem_strobe high after a reset cycle");
			fail_count++;
		end

	wait_in_reset: assert property (@(posedge clk_sys) reset |=> !dl_wait)
		else begin
			$error("dl_wait high after a reset cycle");
			fail_count++;
		end

endmodule

bind media_top media_checker media_checker_i (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.mem_strobe (mem_strobe),
	.dl_wait    (dl_wait)
);

`default_nettype wire

//--- testbench/media_tb.sv
`timescale 1ns/10ps
`default_nettype none

module media_tb import media_pkg::*;;

	localparam int TAPE_LEN   = 12;
	localparam int WAIT_LIMIT = 4 * SLOT_DIV;

	typedef struct packed {
		byte_t       index;
		logic [15:0] ext;
		dl_addr_t    addr;
		byte_t       data;
		logic        has_write;
		mem_addr_t   exp_addr;
		logic        map_set;
		byte_t       map_bit;
	} rom_entry_t;

	logic         clk_sys;
	logic         reset;
	dl_t          dl;
	logic         download;
	byte_t        dl_index;
	logic [15:0]  dl_ext;
	logic         dl_wait;
	logic         tape_req;
	logic         tape_rewind;
	logic         tape_ack;
	byte_t        tape_data;
	logic         mem_strobe;
	mem_req_t     mem_req;
	byte_t        mem_rdata;
	logic [255:0] rom_map;

	rom_entry_t   rom_table[$];
	mem_req_t     wr_log[$];
	byte_t        mem_model [mem_addr_t];
	byte_t        tape_bytes [TAPE_LEN];
	logic [255:0] exp_map;
	int           seed = 3060;

	tb_clock clock_i (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	media_top dut_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.download    (download),
		.dl_index    (dl_index),
		.dl_ext      (dl_ext),
		.dl_wait     (dl_wait),
		.tape_req    (tape_req),
		.tape_rewind (tape_rewind),
		.tape_ack    (tape_ack),
		.tape_data   (tape_data),
		.mem_strobe  (mem_strobe),
		.mem_req     (mem_req),
		.mem_rdata   (mem_rdata),
		.rom_map     (rom_map)
	);

	//////////////////////////////
	// External memory model
	//////////////////////////////
	initial mem_rdata = 8'h00;

	// Read data shows up the cycle after the strobe
	always @(posedge clk_sys) begin
		if (mem_strobe) begin
			if (mem_req.we) begin
				mem_model[mem_req.addr] = mem_req.data;
				wr_log.push_back(mem_req);
			end else if (mem_model.exists(mem_req.addr)) begin
				mem_rdata <= mem_model[mem_req.addr];
			end else begin
				mem_rdata <= 8'h00;
			end
		end
	end

	//////////////////////////////
	// Check and helper tasks
	//////////////////////////////
	task automatic check_value(input string what, input logic [255:0] got,
			input logic [255:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, expected);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		$display("Finished with errors");
		$fatal(1, "wait timed out");
	endtask

	function automatic mem_addr_t mem_at(input bank_t bank, input page_t page,
			input logic [13:0] offset);
		return {bank, page, offset};
	endfunction

	task automatic add_entry(input byte_t index, input logic [15:0] ext,
			input dl_addr_t addr, input byte_t data, input logic has_write,
			input mem_addr_t exp_addr, input logic map_set, input byte_t map_bit);
		rom_entry_t e;
		e = {index, ext, addr, data, has_write, exp_addr, map_set, map_bit};
		rom_table.push_back(e);
	endtask

	task automatic build_table();
		// Expansion files first while the map is still clear
		add_entry(8'd1, "1A", 25'h0000007, 8'h11, 1'b1,
			mem_at(BANK_MODEL_A, 9'h01A, 14'h0007), 1'b0, 8'h00);
		add_entry(8'd1, "1A", 25'h0008100, 8'h12, 1'b1,
			mem_at(BANK_MODEL_A, 9'h01C, 14'h0100), 1'b0, 8'h00);
		add_entry(8'd2, "FF", 25'h0000033, 8'h21, 1'b1,
			mem_at(BANK_MODEL_A, 9'h0FF, 14'h0033), 1'b0, 8'h00);
		add_entry(8'd2, "FF", 25'h0400033, 8'h22, 1'b1,
			mem_at(BANK_MODEL_A, 9'h1FF, 14'h0033), 1'b1, 8'hFF);
		add_entry(8'd3, "ZZ", 25'h0004010, 8'h31, 1'b1,
			mem_at(BANK_MODEL_A, 9'h001, 14'h0010), 1'b0, 8'h00);
		add_entry(8'd5, "Q?", 25'h0000200, 8'h41, 1'b1,
			mem_at(BANK_MODEL_A, 9'h1EE, 14'h0200), 1'b1, 8'hEE);
		// System ROM, BASIC and disk pages sit in the upper half
		add_entry(8'd0, 16'h0000, 25'h0000123, 8'h80, 1'b1,
			mem_at(BANK_MODEL_A, 9'h000, 14'h0123), 1'b0, 8'h00);
		add_entry(8'd0, 16'h0000, 25'h0004042, 8'h81, 1'b1,
			mem_at(BANK_MODEL_A, 9'h100, 14'h0042), 1'b1, 8'h00);
		add_entry(8'd0, 16'h0000, 25'h000BFFF, 8'h82, 1'b1,
			mem_at(BANK_MODEL_A, 9'h107, 14'h3FFF), 1'b1, 8'h07);
		add_entry(8'd0, 16'h0000, 25'h000C001, 8'h83, 1'b1,
			mem_at(BANK_MODEL_A, 9'h0FF, 14'h0001), 1'b0, 8'h00);
		add_entry(8'd0, 16'h0000, 25'h0012000, 8'h84, 1'b1,
			mem_at(BANK_MODEL_B, 9'h000, 14'h2000), 1'b0, 8'h00);
		add_entry(8'd0, 16'h0000, 25'h0014010, 8'h85, 1'b1,
			mem_at(BANK_MODEL_B, 9'h100, 14'h0010), 1'b1, 8'h00);
		add_entry(8'd0, 16'h0000, 25'h0019234, 8'h86, 1'b1,
			mem_at(BANK_MODEL_B, 9'h107, 14'h1234), 1'b1, 8'h07);
		add_entry(8'd0, 16'h0000, 25'h001CABC, 8'h87, 1'b1,
			mem_at(BANK_MODEL_B, 9'h0FF, 14'h0ABC), 1'b0, 8'h00);
		// Segment 8 is unmapped
		add_entry(8'd0, 16'h0000, 25'h0020005, 8'h88, 1'b0, '0, 1'b0, 8'h00);
	endtask

	task automatic apply_rom_entry(input rom_entry_t e);
		int wait_cnt;
		@(negedge clk_sys);
		download = 1'b1;
		dl_index = e.index;
		dl_ext   = e.ext;
		// One idle cycle so the page is latched before the strobe
		@(negedge clk_sys);
		dl.wr   = 1'b1;
		dl.addr = e.addr;
		dl.data = e.data;
		@(negedge clk_sys);
		dl.wr = 1'b0;
		check_value("dl_wait after strobe", 256'(dl_wait), 256'(1'b1));
		wait_cnt = 0;
		while (dl_wait) begin
			if (wait_cnt == WAIT_LIMIT)
				report_timeout("dl_wait to fall");
			wait_cnt++;
			@(negedge clk_sys);
		end
		if (e.has_write) begin
			check_value("ROM write count", 256'(wr_log.size()), 256'(1));
			check_value("ROM write address", 256'(wr_log[0].addr), 256'(e.exp_addr));
			check_value("ROM write data", 256'(wr_log[0].data), 256'(e.data));
		end else begin
			check_value("ROM write count", 256'(wr_log.size()), 256'(0));
		end
		wr_log.delete();
		if (e.map_set)
			exp_map[e.map_bit] = 1'b1;
		check_value("rom_map", rom_map, exp_map);
		download = 1'b0;
	endtask

	task automatic load_tape();
		int i;
		int gap;
		int wait_cnt;
		@(negedge clk_sys);
		download = 1'b1;
		dl_index = TAPE_INDEX;
		dl_ext   = 16'h0000;
		@(negedge clk_sys);
		for (i = 0; i < TAPE_LEN; i++) begin
			tape_bytes[i] = byte_t'($random(seed));
			dl.wr   = 1'b1;
			dl.addr = dl_addr_t'(i);
			dl.data = tape_bytes[i];
			@(negedge clk_sys);
			dl.wr    = 1'b0;
			gap      = 1;
			wait_cnt = 0;
			while (wr_log.size() == 0) begin
				check_value("dl_wait during tape", 256'(dl_wait), 256'(1'b0));
				if (wait_cnt == WAIT_LIMIT)
					report_timeout("tape write");
				wait_cnt++;
				gap++;
				@(negedge clk_sys);
			end
			// Host spacing of two slot periods between tape strobes
			while (gap < 2 * SLOT_DIV) begin
				check_value("dl_wait during tape", 256'(dl_wait), 256'(1'b0));
				gap++;
				@(negedge clk_sys);
			end
			check_value("tape write count", 256'(wr_log.size()), 256'(1));
			check_value("tape write address", 256'(wr_log[0].addr),
				256'(mem_at(BANK_TAPE, page_t'(i >> 14), 14'(i))));
			check_value("tape write data", 256'(wr_log[0].data), 256'(tape_bytes[i]));
			wr_log.delete();
		end
		download = 1'b0;
	endtask

	task automatic fetch_tape(input byte_t expected);
		int wait_cnt;
		@(negedge clk_sys);
		tape_req = ~tape_req;
		wait_cnt = 0;
		@(negedge clk_sys);
		while (tape_ack != tape_req) begin
			if (wait_cnt == WAIT_LIMIT)
				report_timeout("tape_ack");
			wait_cnt++;
			@(negedge clk_sys);
		end
		check_value("tape_data", 256'(tape_data), 256'(expected));
	endtask

	task automatic rewind_tape();
		@(negedge clk_sys);
		tape_rewind = 1'b1;
		@(negedge clk_sys);
		tape_rewind = 1'b0;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		int k;
		int wait_cnt;
		dl          = '0;
		download    = 1'b0;
		dl_index    = 8'd0;
		dl_ext      = 16'h0000;
		tape_req    = 1'b0;
		tape_rewind = 1'b0;
		exp_map     = '0;
		build_table();

		@(negedge clk_sys);
		wait_cnt = 0;
		while (reset) begin
			if (wait_cnt == WAIT_LIMIT)
				report_timeout("reset release");
			wait_cnt++;
			@(negedge clk_sys);
		end
		check_value("dl_wait after reset", 256'(dl_wait), 256'(1'b0));
		check_value("rom_map after reset", rom_map, 256'(0));
		check_value("tape_ack after reset", 256'(tape_ack), 256'(1'b0));

		foreach (rom_table[n])
			apply_rom_entry(rom_table[n]);

		load_tape();

		// Playback stops on the last byte
		for (k = 0; k < TAPE_LEN; k++)
			fetch_tape(tape_bytes[k]);
		fetch_tape(tape_bytes[TAPE_LEN-1]);
		fetch_tape(tape_bytes[TAPE_LEN-1]);

		rewind_tape();
		fetch_tape(tape_bytes[0]);
		fetch_tape(tape_bytes[1]);

		repeat (2) @(negedge clk_sys);
		if (dut_i.media_checker_i.fail_count != 0) begin
			$display("Bound assertions failed during the run");
			$display("Finished with errors");
			$fatal(1, "assertion failures");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	// 40 ns period
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Reset held for three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire
